/* src/uart_periph_pkg.sv */
// Shared constants for the memory-mapped UART peripheral.
// Bus field positions, register map, status bits and serial frame settings.
// Import it with a wildcard inside a module body, or use scoped names in a header.

package uart_periph_pkg;

    // ------------------------------------------------------------------
    // Serial frame
    // ------------------------------------------------------------------
    // Payload bits per 8N1 frame
    localparam int DATA_BITS = 8;
    // Clock ticks per prescale unit, so one bit is prescale * 8 clocks
    localparam int OVERSAMPLE = 8;
    localparam logic [15:0] PRESCALE_RESET = 16'd1;

    // ------------------------------------------------------------------
    // Packed memory bus
    // ------------------------------------------------------------------
    localparam int FWD_W = 69;
    localparam int RET_W = 33;

    // Forward word from the top: valid, addr[31:0], wdata[31:0], wstrb[3:0]
    localparam int FWD_VALID_BIT = 68;
    localparam int FWD_ADDR_LSB  = 36;
    localparam int FWD_WDATA_LSB = 4;
    localparam int FWD_WSTRB_LSB = 0;

    // Return word: ready on top, read data below
    localparam int RET_READY_BIT = 32;

    // ------------------------------------------------------------------
    // Register map, byte offsets on addr[3:0]
    // ------------------------------------------------------------------
    localparam logic [3:0] REG_TX     = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_RX     = 4'h8;
    localparam logic [3:0] REG_BAUD   = 4'hC;

    // Status register bits
    localparam int STAT_TX_BUSY   = 0;
    localparam int STAT_RX_BUSY   = 1;
    localparam int STAT_OVERRUN   = 2;
    localparam int STAT_FRAME_ERR = 3;

    // RX register read while no byte is held
    localparam logic [31:0] RX_EMPTY_CODE = 32'hFFFF_FF00;

endpackage

/* src/uart_tx.sv */
// UART transmit engine, 8N1.
// Accepts one byte on a valid/ready handshake while idle and shifts it out
// on txd LSB first, framed by a start and a stop bit.

module uart_tx (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [15:0]                           prescale,
    input  logic [uart_periph_pkg::DATA_BITS-1:0] tx_data,
    input  logic                                  tx_valid,
    output logic                                  tx_ready,
    output logic                                  txd,
    output logic                                  tx_busy
);

    import uart_periph_pkg::*;

    // Wide enough for prescale * OVERSAMPLE
    localparam int TICK_W  = 16 + $clog2(OVERSAMPLE);
    localparam int FRAME_W = DATA_BITS + 2;

    // Stop, data, start with the start bit at bit 0
    logic [FRAME_W-1:0] shreg;
    // Bits still to send after the one on the line
    logic [3:0]         bit_cnt;
    logic [TICK_W-1:0]  tick_cnt;
    logic [TICK_W-1:0]  bit_len;
    logic               busy;

    // Clocks per bit period
    assign bit_len = TICK_W'(prescale) * TICK_W'(OVERSAMPLE);

    // Only take a byte when fully idle
    assign tx_ready = !busy;
    assign tx_busy  = busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            txd      <= 1'b1;
            bit_cnt  <= '0;
            tick_cnt <= '0;
        end else if (!busy) begin
            // Idle line is high
            txd <= 1'b1;
            if (tx_valid) begin
                // Start bit goes out right away, one cycle after acceptance
                shreg    <= {1'b1, tx_data, 1'b0};
                txd      <= 1'b0;
                bit_cnt  <= 4'(FRAME_W - 1);
                tick_cnt <= bit_len - 1'b1;
                busy     <= 1'b1;
            end
        end else if (tick_cnt != '0) begin
            tick_cnt <= tick_cnt - 1'b1;
        end else if (bit_cnt == '0) begin
            // Stop bit done, line already high
            busy <= 1'b0;
            txd  <= 1'b1;
        end else begin
            // Next bit, LSB first; ones fill in from the top
            shreg    <= {1'b1, shreg[FRAME_W-1:1]};
            txd      <= shreg[1];
            bit_cnt  <= bit_cnt - 1'b1;
            tick_cnt <= bit_len - 1'b1;
        end
    end

endmodule

/* src/uart_rx.sv */
// UART receive engine, 8N1.
// Synchronizes rxd, confirms a start edge at half a bit, samples each bit
// at its center and offers the byte on a valid/ready stream.
// Flags overrun when a byte is replaced and frame error on a low stop bit.

module uart_rx (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [15:0]                           prescale,
    input  logic                                  rxd,
    output logic [uart_periph_pkg::DATA_BITS-1:0] rx_data,
    output logic                                  rx_valid,
    input  logic                                  rx_ready,
    output logic                                  rx_busy,
    output logic                                  overrun,
    output logic                                  frame_err
);

    import uart_periph_pkg::*;

    localparam int TICK_W = 16 + $clog2(OVERSAMPLE);

    // Two-flop synchronizer plus one more stage for edge detection
    logic                 rxd_meta;
    logic                 rxd_s;
    logic                 rxd_d;

    logic [DATA_BITS-1:0] shreg;
    // 0 is start check, 1..8 data bits, 9 stop bit
    logic [3:0]           bit_cnt;
    logic [TICK_W-1:0]    tick_cnt;
    logic [TICK_W-1:0]    bit_len;
    logic                 busy;
    logic                 start_edge;

    assign bit_len    = TICK_W'(prescale) * TICK_W'(OVERSAMPLE);
    // Falling edge only, so a line stuck low after a bad stop bit is ignored
    assign start_edge = rxd_d && !rxd_s;
    assign rx_busy    = busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_d    <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
            rxd_d    <= rxd_s;
        end
    end

    // ------------------------------------------------------------------
    // Bit timing and sampling
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            bit_cnt   <= '0;
            tick_cnt  <= '0;
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            // Byte taken by the register block
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
                overrun  <= 1'b0;
            end

            if (!busy) begin
                if (start_edge) begin
                    // Wait half a bit to land mid start bit
                    busy     <= 1'b1;
                    bit_cnt  <= '0;
                    tick_cnt <= (bit_len >> 1) - 1'b1;
                end
            end else if (tick_cnt != '0) begin
                tick_cnt <= tick_cnt - 1'b1;
            end else if (bit_cnt == '0) begin
                // Start bit still low, else it was a glitch
                if (!rxd_s) begin
                    bit_cnt  <= 4'd1;
                    tick_cnt <= bit_len - 1'b1;
                end else begin
                    busy <= 1'b0;
                end
            end else if (bit_cnt <= 4'(DATA_BITS)) begin
                // Data bit center, LSB arrives first
                shreg    <= {rxd_s, shreg[DATA_BITS-1:1]};
                bit_cnt  <= bit_cnt + 1'b1;
                tick_cnt <= bit_len - 1'b1;
            end else begin
                // Middle of the stop bit
                busy <= 1'b0;
                if (rxd_s) begin
                    rx_data   <= shreg;
                    rx_valid  <= 1'b1;
                    frame_err <= 1'b0;
                    // Old byte still waiting and not taken this cycle
                    overrun   <= rx_valid && !rx_ready;
                end else begin
                    // Low stop bit, drop the byte
                    frame_err <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/uart_regs.sv */
// Bus slave for the UART peripheral.
// Unpacks the forward bus word, decodes the TX, status, RX and baud registers,
// drives the TX and RX streams and packs the registered return word.
// A TX write stalls until the transmitter is idle.

module uart_regs #(
    parameter logic [7:0] BASE_ADDR = 8'h00
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [uart_periph_pkg::FWD_W-1:0]     mem_packed_fwd,
    output logic [uart_periph_pkg::RET_W-1:0]     mem_packed_ret,
    output logic [uart_periph_pkg::DATA_BITS-1:0] tx_data,
    output logic                                  tx_valid,
    input  logic                                  tx_ready,
    input  logic [uart_periph_pkg::DATA_BITS-1:0] rx_data,
    input  logic                                  rx_valid,
    output logic                                  rx_ready,
    input  logic                                  tx_busy,
    input  logic                                  rx_busy,
    input  logic                                  overrun,
    input  logic                                  frame_err,
    output logic [15:0]                           prescale,
    output logic                                  irq_rx_valid
);

    import uart_periph_pkg::*;

    // One-hot access select
    localparam logic [3:0] SEL_TX   = 4'b0001;
    localparam logic [3:0] SEL_STAT = 4'b0010;
    localparam logic [3:0] SEL_RX   = 4'b0100;
    localparam logic [3:0] SEL_BAUD = 4'b1000;

    // ------------------------------------------------------------------
    // Forward word fields
    // ------------------------------------------------------------------
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic [3:0]  short_addr;

    assign mem_valid  = mem_packed_fwd[FWD_VALID_BIT];
    assign mem_addr   = mem_packed_fwd[FWD_ADDR_LSB +: 32];
    assign mem_wdata  = mem_packed_fwd[FWD_WDATA_LSB +: 32];
    assign mem_wstrb  = mem_packed_fwd[FWD_WSTRB_LSB +: 4];
    assign short_addr = mem_addr[3:0];

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    logic        ready_q;
    // Cycle after ready, while the CPU is still dropping valid
    logic        guard_q;
    logic [31:0] rdata_q;
    logic        base_hit;
    logic        req;
    logic        is_write;
    logic [3:0]  sel;

    assign base_hit = mem_addr[31:16] == {BASE_ADDR, 8'h00};
    assign req      = mem_valid && base_hit && !ready_q && !guard_q;
    assign is_write = |mem_wstrb;

    // Reads and writes only match their own registers
    assign sel[0] = req &&  is_write && (short_addr == REG_TX);
    assign sel[1] = req && !is_write && (short_addr == REG_STATUS);
    assign sel[2] = req && !is_write && (short_addr == REG_RX);
    assign sel[3] = req &&  is_write && (short_addr == REG_BAUD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q  <= 1'b0;
            guard_q  <= 1'b0;
            rdata_q  <= '0;
            tx_valid <= 1'b0;
            rx_ready <= 1'b0;
            prescale <= PRESCALE_RESET;
        end else begin
            // Single-cycle pulses by default
            ready_q  <= 1'b0;
            rdata_q  <= '0;
            tx_valid <= 1'b0;
            rx_ready <= 1'b0;
            guard_q  <= ready_q;

            case (sel)
                SEL_TX: begin
                    // Low byte starts a frame, stall while the transmitter works
                    if (mem_wstrb[0]) begin
                        if (tx_ready) begin
                            tx_data  <= mem_wdata[DATA_BITS-1:0];
                            tx_valid <= 1'b1;
                            ready_q  <= 1'b1;
                        end
                    end else begin
                        // Upper lanes only, nothing to send
                        ready_q <= 1'b1;
                    end
                end
                SEL_STAT: begin
                    rdata_q[STAT_TX_BUSY]   <= tx_busy;
                    rdata_q[STAT_RX_BUSY]   <= rx_busy;
                    rdata_q[STAT_OVERRUN]   <= overrun;
                    rdata_q[STAT_FRAME_ERR] <= frame_err;
                    ready_q                 <= 1'b1;
                end
                SEL_RX: begin
                    if (rx_valid) begin
                        rdata_q  <= {{(32 - DATA_BITS){1'b0}}, rx_data};
                        // Tell the receiver the byte is taken
                        rx_ready <= 1'b1;
                    end else begin
                        rdata_q <= RX_EMPTY_CODE;
                    end
                    ready_q <= 1'b1;
                end
                SEL_BAUD: begin
                    if (mem_wstrb[0]) prescale[7:0]  <= mem_wdata[7:0];
                    if (mem_wstrb[1]) prescale[15:8] <= mem_wdata[15:8];
                    ready_q <= 1'b1;
                end
                default: begin
                    // No access, or one this block does not answer
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Return word and interrupt
    // ------------------------------------------------------------------
    assign mem_packed_ret[RET_READY_BIT]     = ready_q;
    assign mem_packed_ret[RET_READY_BIT-1:0] = rdata_q;

    // High while a received byte waits
    assign irq_rx_valid = rx_valid;

endmodule

/* src/uart_periph.sv */
// Memory-mapped UART peripheral top level.
// Joins the register block to the transmit and receive engines.

module uart_periph #(
    parameter logic [7:0] BASE_ADDR = 8'h00
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              rxd,
    output logic                              txd,
    output logic                              irq_rx_valid,
    input  logic [uart_periph_pkg::FWD_W-1:0] mem_packed_fwd,
    output logic [uart_periph_pkg::RET_W-1:0] mem_packed_ret
);

    import uart_periph_pkg::*;

    // TX stream
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_valid;
    logic                 tx_ready;
    // RX stream
    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_valid;
    logic                 rx_ready;
    // Status from the engines
    logic                 tx_busy;
    logic                 rx_busy;
    logic                 overrun;
    logic                 frame_err;
    // Shared bit timing
    logic [15:0]          prescale;

    uart_regs #(
        .BASE_ADDR (BASE_ADDR)
    ) u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_packed_fwd (mem_packed_fwd),
        .mem_packed_ret (mem_packed_ret),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .tx_busy        (tx_busy),
        .rx_busy        (rx_busy),
        .overrun        (overrun),
        .frame_err      (frame_err),
        .prescale       (prescale),
        .irq_rx_valid   (irq_rx_valid)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .prescale (prescale),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    uart_rx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .prescale  (prescale),
        .rxd       (rxd),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .rx_busy   (rx_busy),
        .overrun   (overrun),
        .frame_err (frame_err)
    );

endmodule

/* tb/uart_periph_sva.sv */
// Bus and serial timing checks for the UART peripheral.
// Bound into every uart_periph instance; failures are counted for the testbench.

module uart_periph_sva #(
    parameter logic [7:0] BASE_ADDR = 8'h00
) (
    input logic                              clk,
    input logic                              rst_n,
    input logic [uart_periph_pkg::FWD_W-1:0] mem_packed_fwd,
    input logic [uart_periph_pkg::RET_W-1:0] mem_packed_ret,
    input logic                              txd,
    input logic                              irq_rx_valid,
    input logic                              tx_busy,
    input logic                              rx_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    import uart_periph_pkg::*;

    logic ready;
    logic valid;
    logic base_hit;
    int   assert_fails = 0;

    assign ready    = mem_packed_ret[RET_READY_BIT];
    assign valid    = mem_packed_fwd[FWD_VALID_BIT];
    // Upper half of the address selects this peripheral
    assign base_hit = mem_packed_fwd[FWD_ADDR_LSB + 16 +: 16] == {BASE_ADDR, 8'h00};

    // ------------------------------------------------------------------
    // Bus
    // ------------------------------------------------------------------
    ready_single: assert property (@(posedge clk) disable iff (!rst_n)
        ready |=> !ready)
        else begin
            assert_fails = assert_fails + 1;
            $error("ready high two cycles in a row");
        end

    ready_after_request: assert property (@(posedge clk) disable iff (!rst_n)
        ready |-> $past(valid && base_hit))
        else begin
            assert_fails = assert_fails + 1;
            $error("ready without an accepted request");
        end

    no_ready_other_base: assert property (@(posedge clk) disable iff (!rst_n)
        (valid && !base_hit) |=> !ready)
        else begin
            assert_fails = assert_fails + 1;
            $error("ready after a request outside the base address");
        end

    // ------------------------------------------------------------------
    // Serial side
    // ------------------------------------------------------------------
    txd_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> txd)
        else begin
            assert_fails = assert_fails + 1;
            $error("txd low while the transmitter is idle");
        end

    irq_falls_on_read: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(irq_rx_valid) |-> $past(rx_ready))
        else begin
            assert_fails = assert_fails + 1;
            $error("irq_rx_valid dropped without an RX read");
        end

endmodule

bind uart_periph uart_periph_sva #(
    .BASE_ADDR (BASE_ADDR)
) u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_packed_fwd (mem_packed_fwd),
    .mem_packed_ret (mem_packed_ret),
    .txd            (txd),
    .irq_rx_valid   (irq_rx_valid),
    .tx_busy        (tx_busy),
    .rx_ready       (rx_ready)
);

/* tb/uart_periph_tb.sv */
// Testbench for the memory-mapped UART peripheral.
// Acts as the CPU on the packed bus, loops txd back to rxd or bit-bangs frames,
// and checks read data, TX stalls, status flags and the RX interrupt.
// Bus and serial timing rules are checked by the bound SVA module.

module uart_periph_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import uart_periph_pkg::*;

    localparam logic [31:0] BASE       = 32'h1000_0000;
    localparam logic [31:0] OTHER_BASE = 32'h2000_0000;
    // Bit timing once prescale is 2
    localparam int BIT_CYCLES     = 2 * OVERSAMPLE;
    localparam int FRAME_CYCLES   = 10 * BIT_CYCLES;
    localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES + 800;

    logic             clk;
    logic             rst_n;
    logic             rxd;
    logic             txd;
    logic             irq_rx_valid;
    logic [FWD_W-1:0] fwd;
    logic [RET_W-1:0] ret;
    logic             loopback;
    logic             bang_rxd;
    int               cycle_count;
    int               value_errors;
    int               other_errors;

    // Serial input: own transmitter or bit-banged frames
    assign rxd = loopback ? txd : bang_rxd;

    uart_periph #(
        .BASE_ADDR (8'h10)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .rxd            (rxd),
        .txd            (txd),
        .irq_rx_valid   (irq_rx_valid),
        .mem_packed_fwd (fwd),
        .mem_packed_ret (ret)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Counted on the falling edge so reads at the rising edge are stable
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Checks and bus master
    // ------------------------------------------------------------------
    function automatic void check_value(input string name, input logic [31:0] expected,
                                        input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endfunction

    // Hold valid until ready or max_wait cycles, then drop valid for a cycle
    // Ready is looked at on the falling edge, where the return word is settled
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, input int max_wait,
                              output logic [31:0] rdata, output logic acked);
        int waited;
        waited = 0;
        fwd <= {1'b1, addr, wdata, wstrb};
        @(negedge clk);
        while (!ret[RET_READY_BIT] && waited < max_wait) begin
            @(negedge clk);
            waited++;
        end
        acked = ret[RET_READY_BIT];
        rdata = ret[31:0];
        @(posedge clk);
        fwd <= '0;
        @(posedge clk);
    endtask

    task automatic bus_write(input logic [3:0] offset, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
        logic [31:0] rdata;
        logic        acked;
        // A stalled TX write may wait out a whole frame
        bus_access(BASE | 32'(offset), wdata, wstrb, 2 * FRAME_CYCLES, rdata, acked);
        assert (acked) else begin
            $display("Write to offset %h got no ready", offset);
            other_errors++;
        end
    endtask

    task automatic bus_read(input logic [3:0] offset, output logic [31:0] rdata);
        logic acked;
        bus_access(BASE | 32'(offset), 32'h0, 4'h0, 20, rdata, acked);
        assert (acked) else begin
            $display("Read from offset %h got no ready", offset);
            other_errors++;
        end
    endtask

    // Polled on the falling edge, returns on a rising edge
    task automatic wait_irq(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!irq_rx_valid && waited < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        assert (irq_rx_valid) else begin
            $display("%s: no received byte within %0d cycles", name, waited);
            other_errors++;
        end
        @(posedge clk);
    endtask

    // One idle bit, then start, 8 data bits LSB first and the given stop bit
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        int         i;
        frame = {stop_bit, data, 1'b0};
        bang_rxd <= 1'b1;
        repeat (BIT_CYCLES) @(posedge clk);
        for (i = 0; i < 10; i++) begin
            bang_rxd <= frame[i];
            repeat (BIT_CYCLES) @(posedge clk);
        end
        bang_rxd <= 1'b1;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] rdata;
        logic        acked;
        logic [7:0]  first_byte;
        logic [7:0]  second_byte;
        int          start_cycle;
        int          i;
        int          total;
        void'($urandom(9));
        rst_n        = 1'b0;
        fwd          = '0;
        loopback     = 1'b0;
        bang_rxd     = 1'b1;
        value_errors = 0;
        other_errors = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Idle after reset
        check_value("reset_txd", 32'h1, 32'(txd));
        check_value("reset_irq", 32'h0, 32'(irq_rx_valid));
        bus_read(REG_STATUS, rdata);
        check_value("reset_status", 32'h0, rdata);

        // Empty RX register, then an access this block must ignore
        bus_read(REG_RX, rdata);
        check_value("rx_empty", RX_EMPTY_CODE, rdata);
        bus_access(OTHER_BASE | 32'(REG_STATUS), 32'h0, 4'h0, 20, rdata, acked);
        check_value("other_base_ack", 32'h0, 32'(acked));

        // Prescale 2 for all serial tests
        bus_write(REG_BAUD, 32'd2, 4'b0011);
        loopback <= 1'b1;

        // Loopback of random bytes
        for (i = 0; i < 4; i++) begin
            first_byte = 8'($urandom);
            bus_write(REG_TX, 32'(first_byte), 4'b0001);
            wait_irq("loopback_irq");
            bus_read(REG_RX, rdata);
            check_value("loopback_data", 32'(first_byte), rdata);
            check_value("loopback_irq_clear", 32'h0, 32'(irq_rx_valid));
        end

        // Back-to-back TX writes, the second one stalls
        first_byte  = 8'($urandom);
        second_byte = 8'($urandom);
        bus_write(REG_TX, 32'(first_byte), 4'b0001);
        bus_read(REG_STATUS, rdata);
        check_value("tx_busy_status", 32'h1, 32'(rdata[STAT_TX_BUSY]));
        start_cycle = cycle_count;
        bus_write(REG_TX, 32'(second_byte), 4'b0001);
        // Most of the first frame was still ahead
        assert (cycle_count - start_cycle > 8 * BIT_CYCLES) else begin
            $display("Second TX write finished after %0d cycles without a stall",
                     cycle_count - start_cycle);
            other_errors++;
        end
        wait_irq("first_byte_irq");
        bus_read(REG_RX, rdata);
        check_value("first_byte", 32'(first_byte), rdata);
        wait_irq("second_byte_irq");
        bus_read(REG_RX, rdata);
        check_value("second_byte", 32'(second_byte), rdata);

        // Low stop bit, then a good frame
        loopback <= 1'b0;
        send_frame(8'hA5, 1'b0);
        bus_read(REG_STATUS, rdata);
        check_value("frame_err_set", 32'h8, rdata);
        send_frame(8'h3C, 1'b1);
        wait_irq("good_frame_irq");
        bus_read(REG_STATUS, rdata);
        check_value("frame_err_clear", 32'h0, rdata);
        bus_read(REG_RX, rdata);
        check_value("good_frame_data", 32'h3C, rdata);

        // Two frames with no read between them
        first_byte  = 8'($urandom);
        second_byte = 8'($urandom);
        send_frame(first_byte, 1'b1);
        send_frame(second_byte, 1'b1);
        wait_irq("overrun_irq");
        bus_read(REG_STATUS, rdata);
        check_value("overrun_set", 32'h4, rdata);
        bus_read(REG_RX, rdata);
        check_value("overrun_data", 32'(second_byte), rdata);
        bus_read(REG_STATUS, rdata);
        check_value("overrun_clear", 32'h0, rdata);

        repeat (4) @(posedge clk);
        total = value_errors + other_errors + UUT.u_sva.assert_fails;
        $display("Done: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, UUT.u_sva.assert_fails);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* uart_periph.f */
src/uart_periph_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart_periph.sv
tb/uart_periph_sva.sv
tb/uart_periph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the UART peripheral testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module uart_periph_tb \
    -f uart_periph.f \
    -o uart_periph_sim

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/uart_periph_sim +verilator+error+limit+1000 | tee "$LOG"

if grep -qx "Testbench passed" "$LOG"; then
    echo "Simulation OK"
else
    echo "Simulation did not pass, see $LOG"
    exit 1
fi
